/* common/elevator_pkg.sv */
// Elevator floor logic shared definitions
// Floor numbers, request masks and the structs exchanged with the car
// state machine and the cab panel

package elevator_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Floor sizing
    ////////////////////////////////////////////////////////////////////////////

    // Upper bound on floors the types can carry
    parameter int max_floors = 16;

    // Bits needed for a floor number
    parameter int floor_w = 4;

    // Zero based floor number, 0 is the first floor
    typedef logic [floor_w-1:0] floor_t;

    // One bit per floor, bit i is floor i+1
    typedef logic [max_floors-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////////////////////
    // Car and cab signals
    ////////////////////////////////////////////////////////////////////////////

    // Reported by the car state machine
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Switches and buttons inside the cab
    typedef struct packed {
        logic power;
        logic emergency;
        logic door_open;
        logic door_close;
    } cab_controls_t;

    // Command to the car state machine
    typedef struct packed {
        floor_t target;
        logic   up;
        logic   activate;
    } dispatch_t;

    // Door button permissions
    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_perm_t;

endpackage

/* hdl/door_interlock.sv */
// Door interlock
// Registers the door open and close permissions. Doors only operate
// with the power on and the car stopped, and open wins over close

`timescale 1ns/1ps

module door_interlock (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::cab_controls_t controls,
    input  elevator_pkg::car_status_t   status,
    output elevator_pkg::door_perm_t    doors
);

    logic door_ok;
    logic open_next;
    logic close_next;

    // Powered and standing still
    assign door_ok = controls.power && !status.moving;

    assign open_next = door_ok && controls.door_open;

    // Closing on a passenger holding open is never allowed
    assign close_next = door_ok && controls.door_close && !controls.door_open;

    ////////////////////////////////////////////////////////////////////////////
    // Permission registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            doors.open_allowed  <= 1'b0;
            doors.close_allowed <= 1'b0;
        end else begin
            doors.open_allowed  <= open_next;
            doors.close_allowed <= close_next;
        end
    end

endmodule

/* hdl/elevator_floor_logic.sv */
// Elevator floor logic
// Request lights for hall calls and cab buttons, target floor scheduling
// and door permissions, working beside the car state machine

`timescale 1ns/1ps

module elevator_floor_logic #(
    parameter int num_floors = 11
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_mask_t   floor_call_buttons,
    input  elevator_pkg::floor_mask_t   panel_buttons,
    input  elevator_pkg::cab_controls_t controls,
    input  elevator_pkg::car_status_t   status,
    output elevator_pkg::floor_mask_t   call_lights,
    output elevator_pkg::floor_mask_t   panel_lights,
    output elevator_pkg::dispatch_t     dispatch,
    output elevator_pkg::door_perm_t    doors
);

    ////////////////////////////////////////////////////////////////////////////
    // Request lights
    ////////////////////////////////////////////////////////////////////////////

    // Hall call buttons on each landing
    request_latch #(
        .num_floors (num_floors)
    ) u_call_latch (
        .clock    (clock),
        .reset_n  (reset_n),
        .buttons  (floor_call_buttons),
        .controls (controls),
        .status   (status),
        .lights   (call_lights)
    );

    // Destination buttons inside the cab
    request_latch #(
        .num_floors (num_floors)
    ) u_panel_latch (
        .clock    (clock),
        .reset_n  (reset_n),
        .buttons  (panel_buttons),
        .controls (controls),
        .status   (status),
        .lights   (panel_lights)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Scheduling and doors
    ////////////////////////////////////////////////////////////////////////////

    floor_scheduler #(
        .num_floors (num_floors)
    ) u_scheduler (
        .clock        (clock),
        .reset_n      (reset_n),
        .call_lights  (call_lights),
        .panel_lights (panel_lights),
        .status       (status),
        .controls     (controls),
        .dispatch     (dispatch)
    );

    door_interlock u_doors (
        .clock    (clock),
        .reset_n  (reset_n),
        .controls (controls),
        .status   (status),
        .doors    (doors)
    );

endmodule

/* hdl/request_latch.sv */
// Request latch
// Keeps one lit request mask. Button presses light their floor, and the
// light of the floor where the car stands goes out

`timescale 1ns/1ps

module request_latch #(
    parameter int num_floors = 11
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_mask_t   buttons,
    input  elevator_pkg::cab_controls_t controls,
    input  elevator_pkg::car_status_t   status,
    output elevator_pkg::floor_mask_t   lights
);

    import elevator_pkg::*;

    // Floors that exist in this building
    localparam floor_mask_t valid_mask = floor_mask_t'((32'd1 << num_floors) - 32'd1);

    floor_mask_t car_bit;
    floor_mask_t set_mask;
    floor_mask_t clear_mask;

    // One hot bit of the floor the car reports
    assign car_bit = floor_mask_t'(1) << status.floor;

    ////////////////////////////////////////////////////////////////////////////
    // Set and clear terms
    ////////////////////////////////////////////////////////////////////////////

    // Presses only count with power on and no emergency,
    // and never for the floor the car is at
    always_comb begin
        set_mask = '0;
        if (controls.power && !controls.emergency) begin
            set_mask = buttons & valid_mask & ~car_bit;
        end
    end

    // Stopped car with power on clears its own floor
    always_comb begin
        clear_mask = '0;
        if (controls.power && !status.moving) begin
            clear_mask = car_bit;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Light register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            // Set and clear never hit the same bit
            lights <= (lights | set_mask) & ~clear_mask;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the elevator testbench with Verilator, run it and check the log

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --top-module tb_elevator -f vlog.f -o tb_elevator > "$LOG" 2>&1 \
    && ./obj_dir/tb_elevator >> "$LOG" 2>&1 \
    || echo "TESTBENCH FAILED: build or simulation error" >> "$LOG"

cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* scheduler/floor_scheduler.sv */
// Floor scheduler
// Picks the next target floor from the pending requests, preferring the
// direction the car last travelled, and commands the car to go

`timescale 1ns/1ps

module floor_scheduler #(
    parameter int num_floors = 11
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_mask_t   call_lights,
    input  elevator_pkg::floor_mask_t   panel_lights,
    input  elevator_pkg::car_status_t   status,
    input  elevator_pkg::cab_controls_t controls,
    output elevator_pkg::dispatch_t     dispatch
);

    import elevator_pkg::*;

    floor_mask_t pending;
    logic        at_target;

    // Nearest pending floor on each side of the car
    logic        above_found;
    floor_t      above_floor;
    logic        below_found;
    floor_t      below_floor;

    floor_t      next_target;
    floor_t      target_q;
    logic        up_q;

    // Hall calls and cab requests are served alike
    assign pending = call_lights | panel_lights;

    // A new target is only chosen once the car has arrived and stopped
    assign at_target = !status.moving && (target_q == status.floor);

    ////////////////////////////////////////////////////////////////////////////
    // Search above and below the car
    ////////////////////////////////////////////////////////////////////////////

    // Walk downward so the last hit is the lowest floor above the car
    always_comb begin
        above_found = 1'b0;
        above_floor = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (pending[i] && (i > int'(status.floor))) begin
                above_found = 1'b1;
                above_floor = floor_t'(i);
            end
        end
    end

    // Walk upward so the last hit is the highest floor below the car
    always_comb begin
        below_found = 1'b0;
        below_floor = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (pending[i] && (i < int'(status.floor))) begin
                below_found = 1'b1;
                below_floor = floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Direction preference
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_target = status.floor;
        if (up_q) begin
            // Keep going up while there is work above
            if (above_found) begin
                next_target = above_floor;
            end else if (below_found) begin
                next_target = below_floor;
            end
        end else begin
            // Keep going down while there is work below
            if (below_found) begin
                next_target = below_floor;
            end else if (above_found) begin
                next_target = above_floor;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Target and direction registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_q <= '0;
            up_q     <= 1'b1;
        end else if (at_target) begin
            target_q <= next_target;
            // Idle car keeps its last direction
            if (next_target != status.floor) begin
                up_q <= (next_target > status.floor);
            end
        end
    end

    // Go whenever powered, not in emergency, stopped and away from target
    assign dispatch.activate = controls.power && !controls.emergency &&
                               !status.moving && (target_q != status.floor);
    assign dispatch.target   = target_q;
    assign dispatch.up       = up_q;

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset
// Free running clock with an active low reset held for the first cycles

`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 8
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset_n = 1'b1;
    end

endmodule

/* tests/tb_elevator.sv */
// Elevator floor logic testbench
// Random buttons, car status and cab controls from a fixed seed are checked
// every cycle against a cycle model of lights, target, direction and doors

`timescale 1ns/1ps

module tb_elevator;

    import elevator_pkg::*;

    localparam int num_floors     = 11;
    localparam int num_cycles     = 2000;
    // Random run plus ten percent margin
    localparam int timeout_cycles = num_cycles + num_cycles / 10;

    logic          clock;
    logic          reset_n;
    floor_mask_t   call_buttons;
    floor_mask_t   panel_buttons;
    cab_controls_t controls;
    car_status_t   status;
    floor_mask_t   call_lights;
    floor_mask_t   panel_lights;
    dispatch_t     dispatch;
    door_perm_t    doors;

    // Cycle model state
    floor_mask_t   m_call;
    floor_mask_t   m_panel;
    floor_t        m_target;
    logic          m_up;
    logic          m_open;
    logic          m_close;

    integer        seed;
    int            hold_cycles;
    int            cycle_count = 0;

    tb_clock #(.period_ns(8), .reset_cycles(8)) u_clock (
        .clock   (clock),
        .reset_n (reset_n)
    );

    elevator_floor_logic #(.num_floors(num_floors)) u_dut (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (call_buttons),
        .panel_buttons      (panel_buttons),
        .controls           (controls),
        .status             (status),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .dispatch           (dispatch),
        .doors              (doors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int roll(input int range);
        return int'({$random(seed)} % range);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    // Nearest pending floor on each side picked by the direction preference
    function automatic floor_t pick_target(input floor_mask_t pending, input floor_t floor,
                                           input logic up);
        logic   found_above;
        logic   found_below;
        floor_t above;
        floor_t below;
        int     f;
        found_above = 1'b0;
        found_below = 1'b0;
        above = floor;
        below = floor;
        f = int'(floor);
        for (int d = 1; d < num_floors; d++) begin
            if (!found_above && (f + d < num_floors) && pending[f + d]) begin
                found_above = 1'b1;
                above = floor_t'(f + d);
            end
            if (!found_below && (f - d >= 0) && pending[f - d]) begin
                found_below = 1'b1;
                below = floor_t'(f - d);
            end
        end
        if (up) begin
            return found_above ? above : (found_below ? below : floor);
        end
        return found_below ? below : (found_above ? above : floor);
    endfunction

    function automatic floor_mask_t next_lights(input floor_mask_t lights,
                                                input floor_mask_t buttons);
        floor_mask_t result;
        result = lights;
        for (int i = 0; i < num_floors; i++) begin
            if (controls.power && !controls.emergency && buttons[i] &&
                (i != int'(status.floor))) begin
                result[i] = 1'b1;
            end
            if (controls.power && !status.moving && (i == int'(status.floor))) begin
                result[i] = 1'b0;
            end
        end
        return result;
    endfunction

    // Advance the model by one clock edge with the inputs it sampled
    task automatic step_model();
        floor_mask_t pending;
        floor_t      next;
        pending = m_call | m_panel;
        if (!status.moving && (m_target == status.floor)) begin
            next = pick_target(pending, status.floor, m_up);
            m_target = next;
            if (next != status.floor) begin
                m_up = (next > status.floor);
            end
        end
        m_call  = next_lights(m_call, call_buttons);
        m_panel = next_lights(m_panel, panel_buttons);
        m_open  = controls.power && !status.moving && controls.door_open;
        m_close = controls.power && !status.moving && controls.door_close &&
                  !controls.door_open;
    endtask

    task automatic check_outputs(input string tag);
        logic exp_activate;
        exp_activate = controls.power && !controls.emergency && !status.moving &&
                       (m_target != status.floor);
        check_value({tag, " call_lights"}, 32'(m_call), 32'(call_lights));
        check_value({tag, " panel_lights"}, 32'(m_panel), 32'(panel_lights));
        check_value({tag, " target"}, 32'(m_target), 32'(dispatch.target));
        check_value({tag, " up"}, 32'(m_up), 32'(dispatch.up));
        check_value({tag, " activate"}, 32'(exp_activate), 32'(dispatch.activate));
        check_value({tag, " open_allowed"}, 32'(m_open), 32'(doors.open_allowed));
        check_value({tag, " close_allowed"}, 32'(m_close), 32'(doors.close_allowed));
    endtask

    task automatic drive_inputs();
        call_buttons  = '0;
        panel_buttons = '0;
        for (int i = 0; i < num_floors; i++) begin
            call_buttons[i]  = (roll(16) == 0);
            panel_buttons[i] = (roll(16) == 0);
        end
        // Car stays on a floor for a few cycles and often stops at its target
        if (hold_cycles == 0) begin
            if (roll(4) == 0) begin
                status.floor = m_target;
            end else begin
                status.floor = floor_t'(roll(num_floors));
            end
            hold_cycles = 1 + roll(4);
        end else begin
            hold_cycles--;
        end
        status.moving       = (roll(2) == 1);
        controls.power      = (roll(20) != 0);
        controls.emergency  = (roll(20) == 0);
        controls.door_open  = (roll(2) == 1);
        controls.door_close = (roll(2) == 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed          = 32'h348b;
        hold_cycles   = 0;
        call_buttons  = '0;
        panel_buttons = '0;
        controls      = '0;
        status        = '0;
        m_call        = '0;
        m_panel       = '0;
        m_target      = '0;
        m_up          = 1'b1;
        m_open        = 1'b0;
        m_close       = 1'b0;

        wait (reset_n === 1'b1);
        check_outputs("after reset");

        for (int cycle = 0; cycle < num_cycles; cycle++) begin
            @(posedge clock);
            step_model();
            #1;
            check_outputs($sformatf("cycle %0d", cycle));
            drive_inputs();
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

    // Guard against a run that never reaches its end
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

/* vlog.f */
common/elevator_pkg.sv
hdl/request_latch.sv
scheduler/floor_scheduler.sv
hdl/door_interlock.sv
hdl/elevator_floor_logic.sv
tests/tb_clock.sv
tests/tb_elevator.sv
